//--- logic/pad_control_pkg.sv
//////////////////////////////////////////////////////////////////////
// pad control definitions
// pad positions, function and mode codes and the grouped signal types
// used by the pad output mux, the input demux and their top level
//////////////////////////////////////////////////////////////////////

package pad_control_pkg;

   //////////////////////////////////////////////////////////////////////
   // pad frame geometry
   //////////////////////////////////////////////////////////////////////

   localparam int unsigned N_PADS     = 10;
   localparam int unsigned PAD_CFG_W  = 6;
   localparam int unsigned N_SPI_DATA = 4;

   // position of each pad in the frame, gpio bit k belongs to pad k
   localparam int unsigned PAD_SPIM_SDIO0 = 0;
   localparam int unsigned PAD_SPIM_SDIO1 = 1;
   localparam int unsigned PAD_SPIM_SDIO2 = 2;
   localparam int unsigned PAD_SPIM_SDIO3 = 3;
   localparam int unsigned PAD_SPIM_CSN0  = 4;
   localparam int unsigned PAD_SPIM_SCK   = 5;
   localparam int unsigned PAD_UART_RX    = 6;
   localparam int unsigned PAD_UART_TX    = 7;
   localparam int unsigned PAD_I2C0_SDA   = 8;
   localparam int unsigned PAD_I2C0_SCL   = 9;

   //////////////////////////////////////////////////////////////////////
   // function select and chip mode
   //////////////////////////////////////////////////////////////////////

   // two bit function select of one pad
   typedef enum logic [1:0] {
      PAD_FUNC  = 2'd0,
      PAD_GPIO  = 2'd1,
      PAD_ALT   = 2'd2,
      PAD_EFPGA = 2'd3
   } pad_func_e;

   typedef pad_func_e [N_PADS-1:0] pad_sel_t;

   typedef logic [N_PADS-1:0] pad_vec_t;

   typedef logic [N_PADS-1:0][PAD_CFG_W-1:0] pad_cfg_arr_t;

   // any mode other than asic hands the efpga inputs to the hw path
   typedef enum logic [1:0] {
      MODE_FUNCTIONAL_ASIC      = 2'd0,
      MODE_FUNCTIONAL_FPGA_SPIS = 2'd1,
      MODE_TEST                 = 2'd2
   } fpga_mode_e;

   //////////////////////////////////////////////////////////////////////
   // grouped signals
   //////////////////////////////////////////////////////////////////////

   // value and enable toward the pad frame
   typedef struct packed {
      pad_vec_t out;
      pad_vec_t oe;
   } pad_drive_t;

   // spi master outputs, oen is active low per data line
   typedef struct packed {
      logic                  clk;
      logic                  csn;
      logic [N_SPI_DATA-1:0] oen;
      logic [N_SPI_DATA-1:0] sdo;
   } spim_tx_t;

   typedef struct packed {
      logic scl_out;
      logic scl_oe;
      logic sda_out;
      logic sda_oe;
   } i2c_tx_t;

   // dir high means the gpio bit drives its pad
   typedef struct packed {
      pad_vec_t out;
      pad_vec_t dir;
   } gpio_tx_t;

endpackage

//--- logic/pad_out_mux.sv
//////////////////////////////////////////////////////////////////////
// pad output mux
// picks output value, output enable and pad configuration of every pad
// from its peripheral, gpio, i2c1 alternate or efpga function
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pad_out_mux (
   input  pad_control_pkg::pad_sel_t     pad_sel_i,
   input  pad_control_pkg::spim_tx_t     spim_i,
   input  logic                          uart_tx_i,
   input  pad_control_pkg::i2c_tx_t      i2c0_i,
   input  pad_control_pkg::i2c_tx_t      i2c1_i,
   input  pad_control_pkg::gpio_tx_t     gpio_i,
   input  pad_control_pkg::pad_cfg_arr_t gpio_cfg_i,
   input  pad_control_pkg::pad_cfg_arr_t pad_cfg_i,
   output pad_control_pkg::pad_drive_t   pad_drive_o,
   output pad_control_pkg::pad_cfg_arr_t pad_cfg_o
);

   import pad_control_pkg::*;

   // candidates per pad, one vector per source
   pad_vec_t func_out;
   pad_vec_t func_oe;
   pad_vec_t alt_out;
   pad_vec_t alt_oe;

   //////////////////////////////////////////////////////////////////////
   // peripheral function of each pad
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      // spi data lines drive only while the master enables them
      for (int k = 0; k < N_SPI_DATA; k++) begin
         func_out[PAD_SPIM_SDIO0 + k] = spim_i.sdo[k];
         func_oe[PAD_SPIM_SDIO0 + k]  = ~spim_i.oen[k];
      end

      func_out[PAD_SPIM_CSN0] = spim_i.csn;
      func_oe[PAD_SPIM_CSN0]  = 1'b1;
      func_out[PAD_SPIM_SCK]  = spim_i.clk;
      func_oe[PAD_SPIM_SCK]   = 1'b1;

      // rx pad is input only
      func_out[PAD_UART_RX] = 1'b0;
      func_oe[PAD_UART_RX]  = 1'b0;
      func_out[PAD_UART_TX] = uart_tx_i;
      func_oe[PAD_UART_TX]  = 1'b1;

      // open drain style, the i2c block owns both value and enable
      func_out[PAD_I2C0_SDA] = i2c0_i.sda_out;
      func_oe[PAD_I2C0_SDA]  = i2c0_i.sda_oe;
      func_out[PAD_I2C0_SCL] = i2c0_i.scl_out;
      func_oe[PAD_I2C0_SCL]  = i2c0_i.scl_oe;
   end

   //////////////////////////////////////////////////////////////////////
   // alternate function, i2c1 on pads 2/3 and 6/7
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      alt_out = '0;
      alt_oe  = '0;

      alt_out[PAD_SPIM_SDIO2] = i2c1_i.sda_out;
      alt_oe[PAD_SPIM_SDIO2]  = i2c1_i.sda_oe;
      alt_out[PAD_SPIM_SDIO3] = i2c1_i.scl_out;
      alt_oe[PAD_SPIM_SDIO3]  = i2c1_i.scl_oe;

      alt_out[PAD_UART_RX] = i2c1_i.sda_out;
      alt_oe[PAD_UART_RX]  = i2c1_i.sda_oe;
      alt_out[PAD_UART_TX] = i2c1_i.scl_out;
      alt_oe[PAD_UART_TX]  = i2c1_i.scl_oe;
   end

   //////////////////////////////////////////////////////////////////////
   // per pad selection
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int k = 0; k < N_PADS; k++) begin
         case (pad_sel_i[k])
            PAD_FUNC: begin
               pad_drive_o.out[k] = func_out[k];
               pad_drive_o.oe[k]  = func_oe[k];
            end
            PAD_GPIO: begin
               pad_drive_o.out[k] = gpio_i.out[k];
               pad_drive_o.oe[k]  = gpio_i.dir[k];
            end
            PAD_ALT: begin
               pad_drive_o.out[k] = alt_out[k];
               pad_drive_o.oe[k]  = alt_oe[k];
            end
            // efpga pads are driven outside this block
            default: begin
               pad_drive_o.out[k] = 1'b0;
               pad_drive_o.oe[k]  = 1'b0;
            end
         endcase
      end
   end

   // gpio pads use the gpio config, everything else the default one
   for (genvar k = 0; k < N_PADS; k++) begin : g_pad_cfg
      assign pad_cfg_o[k] = (pad_sel_i[k] == PAD_GPIO) ? gpio_cfg_i[k] : pad_cfg_i[k];
   end

endmodule

//--- logic/pad_in_demux.sv
//////////////////////////////////////////////////////////////////////
// pad input demux
// routes pad inputs back to spi, uart, i2c0, i2c1, gpio and the efpga
// and chooses between the hw and sw efpga input paths
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pad_in_demux (
   input  pad_control_pkg::pad_sel_t                pad_sel_i,
   input  pad_control_pkg::pad_vec_t                pad_in_i,
   input  pad_control_pkg::fpga_mode_e              mode_i,
   input  pad_control_pkg::pad_vec_t                fpga_in_hw_i,
   output logic [pad_control_pkg::N_SPI_DATA-1:0]   spi_sdi_o,
   output logic                                     uart_rx_o,
   output logic                                     i2c0_sda_in_o,
   output logic                                     i2c0_scl_in_o,
   output logic                                     i2c1_sda_in_o,
   output logic                                     i2c1_scl_in_o,
   output pad_control_pkg::pad_vec_t                gpio_in_o,
   output pad_control_pkg::pad_vec_t                fpga_in_o
);

   import pad_control_pkg::*;

   // efpga inputs as seen through the pad function select
   pad_vec_t fpga_in_sw;

   //////////////////////////////////////////////////////////////////////
   // peripheral inputs
   //////////////////////////////////////////////////////////////////////

   // each spi data input listens to its own pad
   for (genvar k = 0; k < N_SPI_DATA; k++) begin : g_spi_sdi
      assign spi_sdi_o[k] = (pad_sel_i[PAD_SPIM_SDIO0 + k] == PAD_FUNC) ?
                            pad_in_i[PAD_SPIM_SDIO0 + k] : 1'b0;
   end

   // idle level of uart and i2c lines is high
   assign uart_rx_o = (pad_sel_i[PAD_UART_RX] == PAD_FUNC) ? pad_in_i[PAD_UART_RX] : 1'b1;

   assign i2c0_sda_in_o = (pad_sel_i[PAD_I2C0_SDA] == PAD_FUNC) ?
                          pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign i2c0_scl_in_o = (pad_sel_i[PAD_I2C0_SCL] == PAD_FUNC) ?
                          pad_in_i[PAD_I2C0_SCL] : 1'b1;

   //////////////////////////////////////////////////////////////////////
   // i2c1 on its alternate pads
   //////////////////////////////////////////////////////////////////////

   // pads 2/3 win over pads 6/7 when both pairs are in alt
   always_comb begin
      if (pad_sel_i[PAD_SPIM_SDIO2] == PAD_ALT) begin
         i2c1_sda_in_o = pad_in_i[PAD_SPIM_SDIO2];
      end else if (pad_sel_i[PAD_UART_RX] == PAD_ALT) begin
         i2c1_sda_in_o = pad_in_i[PAD_UART_RX];
      end else begin
         i2c1_sda_in_o = 1'b1;
      end

      if (pad_sel_i[PAD_SPIM_SDIO3] == PAD_ALT) begin
         i2c1_scl_in_o = pad_in_i[PAD_SPIM_SDIO3];
      end else if (pad_sel_i[PAD_UART_TX] == PAD_ALT) begin
         i2c1_scl_in_o = pad_in_i[PAD_UART_TX];
      end else begin
         i2c1_scl_in_o = 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // gpio and efpga
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int k = 0; k < N_PADS; k++) begin
         gpio_in_o[k]  = (pad_sel_i[k] == PAD_GPIO) ? pad_in_i[k] : 1'b0;
         fpga_in_sw[k] = (pad_sel_i[k] == PAD_EFPGA) ? pad_in_i[k] : 1'b0;
      end
   end

   // outside asic mode the efpga gets its inputs straight from hw,
   // overriding whatever the pad selects say
   assign fpga_in_o = (mode_i != MODE_FUNCTIONAL_ASIC) ? fpga_in_hw_i : fpga_in_sw;

endmodule

//--- logic/pad_control.sv
//////////////////////////////////////////////////////////////////////
// pad control
// pad multiplexer for the ten pad frame, output side and input side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pad_control (
   // software pad selection and configuration
   input  pad_control_pkg::pad_sel_t                pad_sel_i,
   input  pad_control_pkg::pad_cfg_arr_t            gpio_cfg_i,
   input  pad_control_pkg::pad_cfg_arr_t            pad_cfg_i,
   input  pad_control_pkg::fpga_mode_e              mode_i,

   // peripherals toward the pads
   input  pad_control_pkg::spim_tx_t                spim_i,
   input  logic                                     uart_tx_i,
   input  pad_control_pkg::i2c_tx_t                 i2c0_i,
   input  pad_control_pkg::i2c_tx_t                 i2c1_i,
   input  pad_control_pkg::gpio_tx_t                gpio_i,
   input  pad_control_pkg::pad_vec_t                fpga_in_hw_i,

   // peripherals from the pads
   output logic [pad_control_pkg::N_SPI_DATA-1:0]   spi_sdi_o,
   output logic                                     uart_rx_o,
   output logic                                     i2c0_sda_in_o,
   output logic                                     i2c0_scl_in_o,
   output logic                                     i2c1_sda_in_o,
   output logic                                     i2c1_scl_in_o,
   output pad_control_pkg::pad_vec_t                gpio_in_o,
   output pad_control_pkg::pad_vec_t                fpga_in_o,

   // pad frame
   input  pad_control_pkg::pad_vec_t                pad_in_i,
   output pad_control_pkg::pad_drive_t              pad_drive_o,
   output pad_control_pkg::pad_cfg_arr_t            pad_cfg_o
);

   // drive side, value, enable and config per pad
   pad_out_mux pad_out_mux_inst (
      .pad_sel_i   (pad_sel_i),
      .spim_i      (spim_i),
      .uart_tx_i   (uart_tx_i),
      .i2c0_i      (i2c0_i),
      .i2c1_i      (i2c1_i),
      .gpio_i      (gpio_i),
      .gpio_cfg_i  (gpio_cfg_i),
      .pad_cfg_i   (pad_cfg_i),
      .pad_drive_o (pad_drive_o),
      .pad_cfg_o   (pad_cfg_o)
   );

   // receive side, same select word
   pad_in_demux pad_in_demux_inst (
      .pad_sel_i     (pad_sel_i),
      .pad_in_i      (pad_in_i),
      .mode_i        (mode_i),
      .fpga_in_hw_i  (fpga_in_hw_i),
      .spi_sdi_o     (spi_sdi_o),
      .uart_rx_o     (uart_rx_o),
      .i2c0_sda_in_o (i2c0_sda_in_o),
      .i2c0_scl_in_o (i2c0_scl_in_o),
      .i2c1_sda_in_o (i2c1_sda_in_o),
      .i2c1_scl_in_o (i2c1_scl_in_o),
      .gpio_in_o     (gpio_in_o),
      .fpga_in_o     (fpga_in_o)
   );

endmodule

//--- tb/pad_control_tests.svh
//////////////////////////////////////////////////////////////////////
// pad control directed tests
// stimulus helpers, reference model of the pad rules and the tests
//////////////////////////////////////////////////////////////////////

`ifndef PAD_CONTROL_TESTS_SVH
`define PAD_CONTROL_TESTS_SVH

function automatic pad_sel_t fill_sel(input pad_func_e f);
   pad_sel_t s;
   for (int k = 0; k < N_PADS; k++) begin
      s[k] = f;
   end
   return s;
endfunction

// new values on every input except the selects and the mode
task automatic randomize_inputs();
   spim_i       = spim_tx_t'(rand_bits(10));
   uart_tx_i    = 1'(rand_bits(1));
   i2c0_i       = i2c_tx_t'(rand_bits(4));
   i2c1_i       = i2c_tx_t'(rand_bits(4));
   gpio_i       = gpio_tx_t'(rand_bits(2 * N_PADS));
   gpio_cfg_i   = pad_cfg_arr_t'({30'(rand_bits(30)), 30'(rand_bits(30))});
   pad_cfg_i    = pad_cfg_arr_t'({30'(rand_bits(30)), 30'(rand_bits(30))});
   fpga_in_hw_i = pad_vec_t'(rand_bits(N_PADS));
   pad_in_i     = pad_vec_t'(rand_bits(N_PADS));
endtask

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

// peripheral input reads its idle level when the pad has another function
function automatic logic func_in(input int unsigned p, input logic idle);
   return (pad_sel_i[p] == PAD_FUNC) ? pad_in_i[p] : idle;
endfunction

// i2c1 input follows the first alt pad of the pair and idles high
function automatic logic alt_in(input int unsigned pa, input int unsigned pb);
   return (pad_sel_i[pa] == PAD_ALT) ? pad_in_i[pa] :
          (pad_sel_i[pb] == PAD_ALT) ? pad_in_i[pb] : 1'b1;
endfunction

function automatic pad_drive_t model_drive();
   pad_drive_t d;
   logic [1:0] v;
   for (int k = 0; k < N_PADS; k++) begin
      // v holds out and oe of pad k
      v = 2'b00;
      if (pad_sel_i[k] == PAD_GPIO) begin
         v = {gpio_i.out[k], gpio_i.dir[k]};
      end else if (pad_sel_i[k] == PAD_ALT && (k == 2 || k == 6)) begin
         v = {i2c1_i.sda_out, i2c1_i.sda_oe};
      end else if (pad_sel_i[k] == PAD_ALT && (k == 3 || k == 7)) begin
         v = {i2c1_i.scl_out, i2c1_i.scl_oe};
      end else if (pad_sel_i[k] == PAD_FUNC) begin
         case (k)
            PAD_SPIM_SDIO0, PAD_SPIM_SDIO1, PAD_SPIM_SDIO2, PAD_SPIM_SDIO3:
               v = {spim_i.sdo[k], ~spim_i.oen[k]};
            PAD_SPIM_CSN0: v = {spim_i.csn, 1'b1};
            PAD_SPIM_SCK:  v = {spim_i.clk, 1'b1};
            PAD_UART_TX:   v = {uart_tx_i, 1'b1};
            PAD_I2C0_SDA:  v = {i2c0_i.sda_out, i2c0_i.sda_oe};
            PAD_I2C0_SCL:  v = {i2c0_i.scl_out, i2c0_i.scl_oe};
            default:       v = 2'b00;
         endcase
      end
      d.out[k] = v[1];
      d.oe[k]  = v[0];
   end
   return d;
endfunction

task automatic compare_with_model();
   pad_cfg_arr_t cfg_exp;
   pad_vec_t     gpio_exp;
   pad_vec_t     fpga_exp;
   pad_vec_t     sdi_exp;
   sdi_exp = '0;
   for (int k = 0; k < N_PADS; k++) begin
      cfg_exp[k]  = (pad_sel_i[k] == PAD_GPIO) ? gpio_cfg_i[k] : pad_cfg_i[k];
      gpio_exp[k] = (pad_sel_i[k] == PAD_GPIO) & pad_in_i[k];
      fpga_exp[k] = (pad_sel_i[k] == PAD_EFPGA) & pad_in_i[k];
      if (k < N_SPI_DATA) begin
         sdi_exp[k] = func_in(k, 1'b0);
      end
   end
   if (mode_i != MODE_FUNCTIONAL_ASIC) begin
      fpga_exp = fpga_in_hw_i;
   end
   check_drive("pad_drive_o", model_drive(), pad_drive_o);
   check_cfg("pad_cfg_o", cfg_exp, pad_cfg_o);
   check_vec("gpio_in_o", gpio_exp, gpio_in_o);
   check_vec("fpga_in_o", fpga_exp, fpga_in_o);
   check_vec("spi_sdi_o", sdi_exp, pad_vec_t'(spi_sdi_o));
   check_vec("uart_rx_o", pad_vec_t'(func_in(PAD_UART_RX, 1'b1)), pad_vec_t'(uart_rx_o));
   check_vec("i2c0_sda_in_o", pad_vec_t'(func_in(PAD_I2C0_SDA, 1'b1)),
             pad_vec_t'(i2c0_sda_in_o));
   check_vec("i2c0_scl_in_o", pad_vec_t'(func_in(PAD_I2C0_SCL, 1'b1)),
             pad_vec_t'(i2c0_scl_in_o));
   check_vec("i2c1_sda_in_o", pad_vec_t'(alt_in(2, 6)), pad_vec_t'(i2c1_sda_in_o));
   check_vec("i2c1_scl_in_o", pad_vec_t'(alt_in(3, 7)), pad_vec_t'(i2c1_scl_in_o));
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic peripheral_mode();
   for (int n = 0; n < 20; n++) begin
      drive_edge();
      randomize_inputs();
      pad_sel_i = fill_sel(PAD_FUNC);
      mode_i    = MODE_FUNCTIONAL_ASIC;
      sample_edge();
      check_vec("gpio_in_o", '0, gpio_in_o);
      check_vec("spi_sdi_o", pad_vec_t'(pad_in_i[3:0]), pad_vec_t'(spi_sdi_o));
      compare_with_model();
   end
endtask

task automatic gpio_mode();
   pad_drive_t exp;
   for (int n = 0; n < 20; n++) begin
      drive_edge();
      randomize_inputs();
      pad_sel_i = fill_sel(PAD_GPIO);
      sample_edge();
      exp.out = gpio_i.out;
      exp.oe  = gpio_i.dir;
      check_drive("pad_drive_o", exp, pad_drive_o);
      check_cfg("pad_cfg_o", gpio_cfg_i, pad_cfg_o);
      check_vec("gpio_in_o", pad_in_i, gpio_in_o);
      check_vec("spi_sdi_o", '0, pad_vec_t'(spi_sdi_o));
      // uart rx and both i2c inputs sit at their idle level
      check_vec("uart_i2c_in", pad_vec_t'(5'h1f), pad_vec_t'({uart_rx_o, i2c0_sda_in_o,
                i2c0_scl_in_o, i2c1_sda_in_o, i2c1_scl_in_o}));
   end
endtask

// n % 4 selects pads 2/3 (0), pads 6/7 (1), both pairs (2) or neither (3)
task automatic i2c1_alternate();
   for (int n = 0; n < 32; n++) begin
      drive_edge();
      randomize_inputs();
      pad_sel_i = fill_sel(PAD_FUNC);
      if (n % 4 == 0 || n % 4 == 2) begin
         pad_sel_i[2] = PAD_ALT;
         pad_sel_i[3] = PAD_ALT;
      end
      if (n % 4 == 1 || n % 4 == 2) begin
         pad_sel_i[6] = PAD_ALT;
         pad_sel_i[7] = PAD_ALT;
      end
      sample_edge();
      check_vec("i2c1_sda_in_o", pad_vec_t'((n % 4 == 3) ? 1'b1 :
                (n % 4 == 1) ? pad_in_i[6] : pad_in_i[2]), pad_vec_t'(i2c1_sda_in_o));
      check_vec("i2c1_scl_in_o", pad_vec_t'((n % 4 == 3) ? 1'b1 :
                (n % 4 == 1) ? pad_in_i[7] : pad_in_i[3]), pad_vec_t'(i2c1_scl_in_o));
      if (pad_sel_i[2] == PAD_ALT) begin
         check_vec("pad_drive_o pad 2", pad_vec_t'({i2c1_i.sda_out, i2c1_i.sda_oe}),
                   pad_vec_t'({pad_drive_o.out[2], pad_drive_o.oe[2]}));
      end
      compare_with_model();
   end
endtask

task automatic efpga_routing();
   for (int n = 0; n < 40; n++) begin
      drive_edge();
      randomize_inputs();
      pad_sel_i = pad_sel_t'(rand_bits(2 * N_PADS));
      mode_i    = (n < 20) ? MODE_FUNCTIONAL_ASIC : MODE_FUNCTIONAL_FPGA_SPIS;
      sample_edge();
      for (int k = 0; k < N_PADS; k++) begin
         if (pad_sel_i[k] == PAD_EFPGA) begin
            check_vec("pad_drive_o efpga pad", '0,
                      pad_vec_t'({pad_drive_o.out[k], pad_drive_o.oe[k]}));
         end
      end
      if (n >= 20) begin
         check_vec("fpga_in_o", fpga_in_hw_i, fpga_in_o);
      end
      compare_with_model();
   end
endtask

task automatic mixed_selects();
   logic [1:0] m;
   for (int n = 0; n < 200; n++) begin
      drive_edge();
      randomize_inputs();
      pad_sel_i = pad_sel_t'(rand_bits(2 * N_PADS));
      m = 2'(rand_bits(2));
      // code 3 has no mode of its own and folds onto test mode
      mode_i = (m == 2'd3) ? MODE_TEST : fpga_mode_e'(m);
      sample_edge();
      compare_with_model();
   end
endtask

`endif

//--- tb/pad_control_tb.sv
//////////////////////////////////////////////////////////////////////
// pad control testbench
// drives the pad multiplexer with directed and random vectors and
// compares every output with a model built from the pad rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pad_control_tb;

   import pad_control_pkg::*;

   localparam int unsigned CLK_PERIOD = 100;
   localparam int unsigned DRIVE_DLY  = 10;
   localparam int unsigned MAX_CYCLES = 2000;

   logic        clk;
   logic        rst_n;
   logic        done;
   int unsigned errors;
   int unsigned checks;
   logic [15:0] lfsr_state;

   // dut inputs
   pad_sel_t     pad_sel_i;
   pad_cfg_arr_t gpio_cfg_i;
   pad_cfg_arr_t pad_cfg_i;
   fpga_mode_e   mode_i;
   spim_tx_t     spim_i;
   logic         uart_tx_i;
   i2c_tx_t      i2c0_i;
   i2c_tx_t      i2c1_i;
   gpio_tx_t     gpio_i;
   pad_vec_t     fpga_in_hw_i;
   pad_vec_t     pad_in_i;

   // dut outputs
   logic [N_SPI_DATA-1:0] spi_sdi_o;
   logic                  uart_rx_o;
   logic                  i2c0_sda_in_o;
   logic                  i2c0_scl_in_o;
   logic                  i2c1_sda_in_o;
   logic                  i2c1_scl_in_o;
   pad_vec_t              gpio_in_o;
   pad_vec_t              fpga_in_o;
   pad_drive_t            pad_drive_o;
   pad_cfg_arr_t          pad_cfg_o;

   pad_control pad_control_inst (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus timing and random source
   //////////////////////////////////////////////////////////////////////

   task automatic drive_edge();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic sample_edge();
      @(posedge clk);
   endtask

   // galois lfsr x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int unsigned n);
      logic [31:0] r;
      r = '0;
      for (int unsigned i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic check_drive(input string name, input pad_drive_t exp, input pad_drive_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_cfg(input string name, input pad_cfg_arr_t exp, input pad_cfg_arr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_vec(input string name, input pad_vec_t exp, input pad_vec_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s expected %h actual %h", name, exp, act);
      end
   endtask

   `include "pad_control_tests.svh"

   initial begin : watchdog
      int unsigned cycles;
      cycles = 0;
      while (!done && cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      if (!done) begin
         $display("timeout, the tests did not finish within %0d clock cycles", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      errors       = 0;
      checks       = 0;
      done         = 1'b0;
      lfsr_state   = 16'd16442;
      rst_n        = 1'b0;
      pad_sel_i    = fill_sel(PAD_FUNC);
      gpio_cfg_i   = '0;
      pad_cfg_i    = '0;
      mode_i       = MODE_FUNCTIONAL_ASIC;
      spim_i       = '0;
      uart_tx_i    = 1'b0;
      i2c0_i       = '0;
      i2c1_i       = '0;
      gpio_i       = '0;
      fpga_in_hw_i = '0;
      pad_in_i     = '0;

      repeat (16) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;

      peripheral_mode();
      gpio_mode();
      i2c1_alternate();
      efpga_routing();
      mixed_selects();

      done = 1'b1;
      $display("%0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- compile.f
+incdir+tb
logic/pad_control_pkg.sv
logic/pad_out_mux.sv
logic/pad_in_demux.sv
logic/pad_control.sv
tb/pad_control_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the pad control testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f compile.f --top-module pad_control_tb -o pad_control_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/pad_control_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$log"; then
   exit 1
fi

exit 0
